// ==== rob_commit.f ====
+incdir+src
src/rob_pkg.sv
src/rob_if.sv
src/rob_alloc.sv
src/rob_complete.sv
src/rob_retire.sv
src/rob_commit_top.sv
dv/rob_commit_asserts.sv
dv/rob_commit_tb.sv

// ==== dv/rob_commit_tb.sv ====
// ##################################################################
// testbench of the reorder buffer and commit stage
// clock, reset, dispatch and completion stimulus, test sequence,
// result lines and final verdict
// ##################################################################

`timescale 1ns/1ps
`include "rob_params.svh"

module rob_commit_tb import rob_pkg::*; ();

    localparam logic [`XLEN-1:0] PC_BASE = 32'h0000_1000;   // same base as the checks
    localparam logic [`XLEN-1:0] TVEC    = 32'h0000_0400;
    localparam int               LIMIT   = 200;             // cycles per wait

    logic                                 clk;
    logic                                 rst;
    logic                                 alloc_valid;
    logic [`XLEN-1:0]                     alloc_pc;
    op_kind_t                             alloc_kind;
    logic [`ROB_TAG_W-1:0]                alloc_tag;
    logic                                 rob_full;
    logic [`EXEC_W-1:0]                   done_valid;
    logic [`EXEC_W-1:0][`ROB_TAG_W-1:0]   done_tag;
    logic [`EXEC_W-1:0]                   done_exc;
    logic [`EXEC_W-1:0]                   done_mispred;
    logic [`EXEC_W-1:0][`CAUSE_W-1:0]     done_cause;
    logic [`EXEC_W-1:0][`XLEN-1:0]        done_target;
    logic [`XLEN-1:0]                     tvec;
    logic [`COMMIT_W-1:0]                 commit_valid;
    logic [`COMMIT_W-1:0][`ROB_TAG_W-1:0] commit_tag;
    logic [`COMMIT_W-1:0][`XLEN-1:0]      commit_pc;
    logic                                 redirect_valid;
    logic [`XLEN-1:0]                     redirect_pc;
    logic                                 exception;
    logic [`XLEN-1:0]                     epc;
    logic [`CAUSE_W-1:0]                  cause;
    logic                                 rob_empty;

    int                    seed;
    int                    tests_run;
    int                    tests_failed;
    int                    timeouts;
    int                    fails_at_start;
    int                    timeouts_at_start;
    logic [`ROB_TAG_W-1:0] issued [$];   // tags waiting for a result

    rob_commit_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic dispatch(input op_kind_t kind, output logic [`ROB_TAG_W-1:0] tag);
        @(negedge clk);
        tag         = alloc_tag;
        alloc_valid = 1'b1;
        alloc_pc    = PC_BASE + {alloc_tag, 2'b00};
        alloc_kind  = kind;
        @(negedge clk);
        alloc_valid = 1'b0;
    endtask

    task automatic set_result(input int p, input logic [`ROB_TAG_W-1:0] tag,
                              input logic exc, input logic mispred);
        done_valid[p]   = 1'b1;
        done_tag[p]     = tag;
        done_exc[p]     = exc;
        done_mispred[p] = mispred;
        done_cause[p]   = `CAUSE_W'(tag);                  // cause is the tag
        done_target[p]  = PC_BASE + {tag, 2'b00} + 32'h100;
    endtask

    task automatic complete_one(input logic [`ROB_TAG_W-1:0] tag,
                                input logic exc, input logic mispred);
        @(negedge clk);
        set_result(0, tag, exc, mispred);
        @(negedge clk);
        done_valid = '0;
    endtask

    // shuffle the pending tags and complete two per cycle
    task automatic complete_shuffled();
        int                    j;
        logic [`ROB_TAG_W-1:0] t;
        for (int i = issued.size() - 1; i > 0; i--) begin
            j         = $unsigned($random(seed)) % (i + 1);
            t         = issued[i];
            issued[i] = issued[j];
            issued[j] = t;
        end
        while (issued.size() > 0) begin
            @(negedge clk);
            done_valid = '0;
            set_result(0, issued.pop_front(), 1'b0, 1'b0);
            if (issued.size() > 0)
                set_result(1, issued.pop_front(), 1'b0, 1'b0);
        end
        @(negedge clk);
        done_valid = '0;
    endtask

    function automatic logic committed(input logic [`ROB_TAG_W-1:0] tag);
        return (commit_valid[0] && commit_tag[0] == tag)
            || (commit_valid[1] && commit_tag[1] == tag);
    endfunction

    task automatic wait_commit(input logic [`ROB_TAG_W-1:0] tag);
        int n;
        n = 0;
        while (!committed(tag) && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!committed(tag)) begin
            $display("timeout: tag %0d was never committed", tag);
            timeouts++;
        end
    endtask

    task automatic wait_redirect();
        int n;
        n = 0;
        while (!redirect_valid && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!redirect_valid) begin
            $display("timeout: no redirect came from the head");
            timeouts++;
        end
    endtask

    task automatic wait_status(input bit want_full);
        int n;
        n = 0;
        while ((want_full ? !rob_full : !rob_empty) && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (want_full ? !rob_full : !rob_empty) begin
            $display("timeout: the ring never became %s", want_full ? "full" : "empty");
            timeouts++;
        end
    endtask

    task automatic start_test();
        fails_at_start    = DUT.u_asserts.fails;
        timeouts_at_start = timeouts;
    endtask

    task automatic end_test(input string name);
        logic ok;
        @(negedge clk);                              // checks sample the last shown cycle
        ok = (DUT.u_asserts.fails == fails_at_start) && (timeouts == timeouts_at_start);
        tests_run++;
        if (!ok)
            tests_failed++;
        $display("test %0d %s: %s", tests_run, name, ok ? "ok" : "FAILED");
    endtask

    initial begin
        logic [`ROB_TAG_W-1:0] t [4];
        logic [`ROB_TAG_W-1:0] tag;
        seed         = 32'h8d41;
        tests_run    = 0;
        tests_failed = 0;
        timeouts     = 0;
        rst          = 1'b1;
        alloc_valid  = 1'b0;
        alloc_pc     = '0;
        alloc_kind   = op_alu;
        done_valid   = '0;
        done_tag     = '0;
        done_exc     = '0;
        done_mispred = '0;
        done_cause   = '0;
        done_target  = '0;
        tvec         = TVEC;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start_test();
        repeat (2) @(negedge clk);
        end_test("reset state");

        start_test();
        for (int i = 0; i < 8; i++) begin
            dispatch(op_alu, tag);
            issued.push_back(tag);
        end
        complete_shuffled();
        wait_commit(tag);                            // youngest of the batch
        end_test("out-of-order completion");

        // oldest commits and the second one faults behind it
        start_test();
        for (int i = 0; i < 4; i++)
            dispatch(op_alu, t[i]);
        complete_one(t[0], 1'b0, 1'b0);
        complete_one(t[2], 1'b0, 1'b0);
        complete_one(t[3], 1'b0, 1'b0);
        complete_one(t[1], 1'b1, 1'b0);
        wait_redirect();
        end_test("exception at head");

        start_test();
        dispatch(op_alu, t[0]);
        dispatch(op_branch, t[1]);
        dispatch(op_alu, t[2]);
        complete_one(t[2], 1'b0, 1'b0);
        complete_one(t[0], 1'b0, 1'b0);
        complete_one(t[1], 1'b0, 1'b1);
        wait_redirect();
        end_test("branch misprediction");

        // ring is empty after the redirect
        start_test();
        dispatch(op_alu, t[0]);
        dispatch(op_alu, t[1]);
        complete_one(t[1], 1'b0, 1'b0);
        complete_one(t[0], 1'b0, 1'b0);
        wait_commit(t[1]);
        end_test("allocation after flush");

        start_test();
        for (int i = 0; i < `ROB_DEPTH && !rob_full; i++) begin
            dispatch(op_alu, tag);
            issued.push_back(tag);
        end
        wait_status(1'b1);
        complete_shuffled();
        wait_status(1'b0);
        end_test("ring full");

        $display("tests %0d, failed %0d, assertion errors %0d, timeouts %0d",
                 tests_run, tests_failed, DUT.u_asserts.fails, timeouts);
        if (tests_failed == 0 && DUT.u_asserts.fails == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== dv/rob_commit_asserts.sv ====
// ##################################################################
// concurrent checks on the reorder buffer top-level ports
// reset state, commit order and pc, exception and mispredict
// redirects, flush, allocation tag, full flag
// checker module bound into the top level
// ##################################################################

`timescale 1ns/1ps
`include "rob_params.svh"

module rob_commit_asserts #(
    parameter logic [`XLEN-1:0] PC_BASE = 32'h0000_1000
) (
    input logic                                 clk,
    input logic                                 rst,
    input logic                                 alloc_valid,
    input logic [`ROB_TAG_W-1:0]                alloc_tag,
    input logic                                 rob_full,
    input logic [`XLEN-1:0]                     tvec,
    input logic [`COMMIT_W-1:0]                 commit_valid,
    input logic [`COMMIT_W-1:0][`ROB_TAG_W-1:0] commit_tag,
    input logic [`COMMIT_W-1:0][`XLEN-1:0]      commit_pc,
    input logic                                 redirect_valid,
    input logic [`XLEN-1:0]                     redirect_pc,
    input logic                                 exception,
    input logic [`XLEN-1:0]                     epc,
    input logic [`CAUSE_W-1:0]                  cause,
    input logic                                 rob_empty
);

    int                    fails = 0;   // failed checks so far
    logic [`ROB_TAG_W-1:0] seen_head;   // head before the commits now shown
    logic [`ROB_TAG_W-1:0] seen_next;   // entry right behind it
    logic [`ROB_TAG_W-1:0] head_now;    // head after them

    function automatic logic [`XLEN-1:0] pc_of(input logic [`ROB_TAG_W-1:0] tag);
        return PC_BASE + {tag, 2'b00};
    endfunction

    assign seen_next = seen_head + 1'b1;
    assign head_now = seen_head + `ROB_TAG_W'(commit_valid[0]) + `ROB_TAG_W'(commit_valid[1]);

    always_ff @(posedge clk) begin
        if (rst)
            seen_head <= '0;
        else
            seen_head <= head_now;
    end

    reset_state: assert property (@(posedge clk)
        rst |=> (commit_valid == '0 && !redirect_valid && !exception && rob_empty))
        else begin
            fails++;
            $error("error after reset commit_valid %h redirect_valid %h exception %h rob_empty %h",
                   commit_valid, redirect_valid, exception, rob_empty);
        end

    slot0_order: assert property (@(posedge clk) disable iff (rst)
        commit_valid[0] |-> (commit_tag[0] == seen_head && commit_pc[0] == pc_of(seen_head)))
        else begin
            fails++;
            $error("error commit_tag[0] %h expected %h, commit_pc[0] %h expected %h",
                   commit_tag[0], seen_head, commit_pc[0], pc_of(seen_head));
        end

    slot1_order: assert property (@(posedge clk) disable iff (rst)
        commit_valid[1] |-> (commit_valid[0] && commit_tag[1] == seen_next
                             && commit_pc[1] == pc_of(seen_next)))
        else begin
            fails++;
            $error(
                "error commit_valid %h commit_tag[1] %h expected %h, commit_pc[1] %h expected %h",
                commit_valid, commit_tag[1], seen_next, commit_pc[1], pc_of(seen_next));
        end

    trap_at_head: assert property (@(posedge clk) disable iff (rst)
        exception |-> (redirect_valid && redirect_pc == tvec && commit_valid == '0
                       && epc == pc_of(seen_head) && cause == `CAUSE_W'(seen_head)))
        else begin
            fails++;
            $error("error redirect_pc %h expected %h, epc %h expected %h, cause %h expected %h",
                   redirect_pc, tvec, epc, pc_of(seen_head), cause, `CAUSE_W'(seen_head));
        end

    mispredict: assert property (@(posedge clk) disable iff (rst)
        (redirect_valid && !exception) |->
            (commit_valid == 2'b01 && redirect_pc == pc_of(seen_head) + 32'h100))
        else begin
            fails++;
            $error("error commit_valid %h redirect_pc %h expected %h",
                   commit_valid, redirect_pc, pc_of(seen_head) + 32'h100);
        end

    flush_empties: assert property (@(posedge clk) disable iff (rst)
        redirect_valid |-> rob_empty)
        else begin
            fails++;
            $error("error rob_empty %h during redirect", rob_empty);
        end

    alloc_at_head: assert property (@(posedge clk) disable iff (rst)
        (alloc_valid && rob_empty) |-> alloc_tag == head_now)
        else begin
            fails++;
            $error("error alloc_tag %h expected %h", alloc_tag, head_now);
        end

    // last free slot taken with nothing leaving
    fills_up: assert property (@(posedge clk) disable iff (rst)
        (alloc_valid && !rob_full && alloc_tag + 1'b1 == head_now) |=>
            (rob_full || commit_valid != '0 || redirect_valid))
        else begin
            fails++;
            $error("error rob_full %h expected 1", rob_full);
        end

endmodule

bind rob_commit_top rob_commit_asserts u_asserts (.*);

// ==== src/rob_commit_top.sv ====
// ##################################################################
// reorder buffer and commit stage top level
// plain ports, ring interface, allocate / complete / retire blocks
// ##################################################################

`timescale 1ns/1ps
`include "rob_params.svh"

module rob_commit_top import rob_pkg::*; (
    input  logic                                 clk,
    input  logic                                 rst,
    // dispatch
    input  logic                                 alloc_valid,
    input  logic [`XLEN-1:0]                     alloc_pc,
    input  op_kind_t                             alloc_kind,
    output logic [`ROB_TAG_W-1:0]                alloc_tag,
    output logic                                 rob_full,
    // completion from the execution ports
    input  logic [`EXEC_W-1:0]                   done_valid,
    input  logic [`EXEC_W-1:0][`ROB_TAG_W-1:0]   done_tag,
    input  logic [`EXEC_W-1:0]                   done_exc,
    input  logic [`EXEC_W-1:0]                   done_mispred,
    input  logic [`EXEC_W-1:0][`CAUSE_W-1:0]     done_cause,
    input  logic [`EXEC_W-1:0][`XLEN-1:0]        done_target,
    // commit and redirect
    input  logic [`XLEN-1:0]                     tvec,
    output logic [`COMMIT_W-1:0]                 commit_valid,
    output logic [`COMMIT_W-1:0][`ROB_TAG_W-1:0] commit_tag,
    output logic [`COMMIT_W-1:0][`XLEN-1:0]      commit_pc,
    output logic                                 redirect_valid,
    output logic [`XLEN-1:0]                     redirect_pc,
    output logic                                 exception,
    output logic [`XLEN-1:0]                     epc,
    output logic [`CAUSE_W-1:0]                  cause,
    output logic                                 rob_empty
);

    rob_if rif ();

    rob_alloc u_alloc (
        .clk          (clk),
        .rst          (rst),
        .alloc_valid  (alloc_valid),
        .alloc_pc     (alloc_pc),
        .alloc_kind   (alloc_kind),
        .alloc_tag    (alloc_tag),
        .rob_full     (rob_full),
        .done_valid   (done_valid),
        .done_tag     (done_tag),
        .done_mispred (done_mispred),
        .done_cause   (done_cause),
        .done_target  (done_target),
        .rif          (rif.alloc)
    );

    rob_complete u_complete (
        .clk        (clk),
        .rst        (rst),
        .done_valid (done_valid),
        .done_tag   (done_tag),
        .done_exc   (done_exc),
        .rif        (rif.complete)
    );

    rob_retire u_retire (
        .clk            (clk),
        .rst            (rst),
        .tvec           (tvec),
        .commit_valid   (commit_valid),
        .commit_tag     (commit_tag),
        .commit_pc      (commit_pc),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .exception      (exception),
        .epc            (epc),
        .cause          (cause),
        .rob_empty      (rob_empty),
        .rif            (rif.retire)
    );

endmodule

// ==== src/rob_retire.sv ====
// ##################################################################
// commit stage of the reorder buffer
// head pointer, in-order retire of up to two entries per cycle,
// exception and misprediction redirect at the head
// ##################################################################

`timescale 1ns/1ps
`include "rob_params.svh"

module rob_retire import rob_pkg::*; (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [`XLEN-1:0]                     tvec,
    output logic [`COMMIT_W-1:0]                 commit_valid,
    output logic [`COMMIT_W-1:0][`ROB_TAG_W-1:0] commit_tag,
    output logic [`COMMIT_W-1:0][`XLEN-1:0]      commit_pc,
    output logic                                 redirect_valid,
    output logic [`XLEN-1:0]                     redirect_pc,
    output logic                                 exception,
    output logic [`XLEN-1:0]                     epc,
    output logic [`CAUSE_W-1:0]                  cause,
    output logic                                 rob_empty,
    rob_if.retire                                rif
);

    logic [`COMMIT_W-1:0][`ROB_TAG_W-1:0] slot_idx;     // head, head+1, ...
    entry_state_t [`COMMIT_W-1:0]         slot_state;
    logic [`COMMIT_W-1:0]                 slot_go;      // slot retires this cycle
    redirect_kind_t                       redir_kind;

    function automatic logic is_mispred(input rob_payload_t p);
        return (p.kind == op_branch) & p.mispred;
    endfunction

    always_comb begin
        for (int i = 0; i < `COMMIT_W; i++) begin
            slot_idx[i]   = rif.head + `ROB_TAG_W'(i);
            slot_state[i] = rif.state[slot_idx[i]];
        end
    end

    assign rif.rd_idx = slot_idx;

    // Slot 0 alone decides a redirect. A faulting head never commits; a
    // mispredicted branch commits and stops every younger slot. A younger
    // slot retires only behind a clean retire and only if it is clean itself.
    always_comb begin
        redir_kind = rd_none;
        slot_go    = '0;
        if (slot_state[0] == st_done_exc) begin
            redir_kind = rd_exception;
        end else if (slot_state[0] == st_done_ok) begin
            slot_go[0] = 1'b1;
            if (is_mispred(rif.rd_data[0]))
                redir_kind = rd_mispredict;
        end
        for (int i = 1; i < `COMMIT_W; i++) begin
            slot_go[i] = slot_go[i-1]
                       & (redir_kind == rd_none)
                       & (slot_state[i] == st_done_ok)
                       & ~is_mispred(rif.rd_data[i]);
        end
    end

    always_comb begin
        rif.retire_count = '0;
        for (int i = 0; i < `COMMIT_W; i++)
            rif.retire_count = rif.retire_count + `RET_CNT_W'(slot_go[i]);
    end

    assign rif.flush = (redir_kind != rd_none);

    // head == tail with a free head slot; full ring has a live head
    assign rob_empty = (rif.head == rif.tail) & (rif.state[rif.head] == st_empty);

    always_ff @(posedge clk) begin
        if (rst) begin
            rif.head       <= '0;
            commit_valid   <= '0;
            redirect_valid <= 1'b0;
            exception      <= 1'b0;
        end else begin
            // covers flush too: mispredict moves past the branch
            rif.head       <= rif.head + `ROB_TAG_W'(rif.retire_count);
            commit_valid   <= slot_go;
            redirect_valid <= rif.flush;
            exception      <= (redir_kind == rd_exception);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `COMMIT_W; i++) begin
            commit_tag[i] <= slot_idx[i];
            commit_pc[i]  <= rif.rd_data[i].pc;
        end
        if (rif.flush) begin
            if (redir_kind == rd_exception)
                redirect_pc <= tvec;                      // trap entry
            else
                redirect_pc <= rif.rd_data[0].target;     // resolved branch target
        end
        if (redir_kind == rd_exception) begin
            epc   <= rif.rd_data[0].pc;
            cause <= rif.rd_data[0].cause;
        end
    end

endmodule

// ==== src/rob_complete.sv ====
// ##################################################################
// entry status array of the reorder buffer
// issue on dispatch, done on completion, empty on retire or flush
// ##################################################################

`timescale 1ns/1ps
`include "rob_params.svh"

module rob_complete import rob_pkg::*; (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [`EXEC_W-1:0]                 done_valid,
    input  logic [`EXEC_W-1:0][`ROB_TAG_W-1:0] done_tag,
    input  logic [`EXEC_W-1:0]                 done_exc,
    rob_if.complete                            rif
);

    logic [`ROB_TAG_W-1:0] ret_idx [`COMMIT_W];   // entries retiring now
    logic [`EXEC_W-1:0]    done_hit;              // completion of a live entry

    always_comb begin
        for (int i = 0; i < `COMMIT_W; i++)
            ret_idx[i] = rif.head + `ROB_TAG_W'(i);
        // stray results for free slots are ignored
        for (int p = 0; p < `EXEC_W; p++)
            done_hit[p] = done_valid[p] & (rif.state[done_tag[p]] == st_issued);
    end

    // Retiring entries are done and a completing entry is still issued, so
    // the clears and the sets of one edge never target the same slot. A
    // full ring blocks dispatch, which keeps the tail off a retiring head.
    always_ff @(posedge clk) begin
        if (rst || rif.flush) begin
            for (int e = 0; e < `ROB_DEPTH; e++)
                rif.state[e] <= st_empty;
        end else begin
            for (int i = 0; i < `COMMIT_W; i++) begin
                if (i < rif.retire_count)
                    rif.state[ret_idx[i]] <= st_empty;
            end
            if (rif.alloc_fire)
                rif.state[rif.tail] <= st_issued;
            for (int p = 0; p < `EXEC_W; p++) begin
                if (done_hit[p]) begin
                    if (done_exc[p])
                        rif.state[done_tag[p]] <= st_done_exc;
                    else
                        rif.state[done_tag[p]] <= st_done_ok;
                end
            end
        end
    end

endmodule

// ==== src/rob_alloc.sv ====
// ##################################################################
// allocation side of the reorder buffer
// tail pointer, occupancy count and full flag, payload store
// ##################################################################

`timescale 1ns/1ps
`include "rob_params.svh"

module rob_alloc import rob_pkg::*; (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               alloc_valid,
    input  logic [`XLEN-1:0]                   alloc_pc,
    input  op_kind_t                           alloc_kind,
    output logic [`ROB_TAG_W-1:0]              alloc_tag,
    output logic                               rob_full,
    input  logic [`EXEC_W-1:0]                 done_valid,
    input  logic [`EXEC_W-1:0][`ROB_TAG_W-1:0] done_tag,
    input  logic [`EXEC_W-1:0]                 done_mispred,
    input  logic [`EXEC_W-1:0][`CAUSE_W-1:0]   done_cause,
    input  logic [`EXEC_W-1:0][`XLEN-1:0]      done_target,
    rob_if.alloc                               rif
);

    rob_payload_t          store [`ROB_DEPTH];   // one payload per entry
    logic [`ROB_TAG_W:0]   count;                // live entries, 0..depth

    assign rob_full       = (count == `ROB_DEPTH);
    assign alloc_tag      = rif.tail;             // new entry lands at tail
    assign rif.alloc_fire = alloc_valid & ~rob_full & ~rif.flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            rif.tail <= '0;
            count    <= '0;
        end else if (rif.flush) begin
            // ring restarts empty right behind what retires now
            rif.tail <= rif.head + `ROB_TAG_W'(rif.retire_count);
            count    <= '0;
        end else begin
            if (rif.alloc_fire)
                rif.tail <= rif.tail + 1'b1;      // wraps at depth
            count <= count + (`ROB_TAG_W+1)'(rif.alloc_fire)
                           - (`ROB_TAG_W+1)'(rif.retire_count);
        end
    end

    always_ff @(posedge clk) begin
        if (rif.alloc_fire) begin
            store[rif.tail].pc      <= alloc_pc;
            store[rif.tail].kind    <= alloc_kind;
            store[rif.tail].mispred <= 1'b0;
        end
        // results land in any order
        for (int p = 0; p < `EXEC_W; p++) begin
            if (done_valid[p]) begin
                store[done_tag[p]].mispred <= done_mispred[p];
                store[done_tag[p]].cause   <= done_cause[p];
                store[done_tag[p]].target  <= done_target[p];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `COMMIT_W; i++)
            rif.rd_data[i] = store[rif.rd_idx[i]];   // async read for retire
    end

endmodule

// ==== src/rob_if.sv ====
// ##################################################################
// ring state shared by allocate, complete and retire
// pointers, retire count, flush, state array, payload reads
// ##################################################################

`timescale 1ns/1ps
`include "rob_params.svh"

interface rob_if import rob_pkg::*; ();

    logic [`ROB_TAG_W-1:0]                tail;           // next free entry
    logic [`ROB_TAG_W-1:0]                head;           // oldest entry
    logic [`RET_CNT_W-1:0]                retire_count;   // entries leaving this cycle
    logic                                 flush;          // head redirect, ring clears
    logic                                 alloc_fire;     // dispatch accepted

    entry_state_t [`ROB_DEPTH-1:0]        state;

    // payload read ports, one per retire slot
    logic [`COMMIT_W-1:0][`ROB_TAG_W-1:0] rd_idx;
    rob_payload_t [`COMMIT_W-1:0]         rd_data;

    modport alloc (
        output tail,
        output alloc_fire,
        output rd_data,
        input  head,
        input  retire_count,
        input  flush,
        input  rd_idx
    );

    modport complete (
        input  tail,
        input  alloc_fire,
        input  flush,
        input  head,
        input  retire_count,
        output state
    );

    modport retire (
        input  state,
        input  tail,
        input  rd_data,
        output head,
        output retire_count,
        output flush,
        output rd_idx
    );

endinterface

// ==== src/rob_pkg.sv ====
// ##################################################################
// shared types of the reorder buffer
// operation kinds, entry states, redirect kinds, entry payload
// ##################################################################

`include "rob_params.svh"

package rob_pkg;

    // kind of the dispatched operation
    typedef enum logic [1:0] {
        op_alu    = 2'd0,
        op_branch = 2'd1,
        op_system = 2'd2
    } op_kind_t;

    // life of one ring entry
    typedef enum logic [1:0] {
        st_empty    = 2'd0,   // free slot
        st_issued   = 2'd1,   // dispatched, result pending
        st_done_ok  = 2'd2,   // result back, clean
        st_done_exc = 2'd3    // result back, faulted
    } entry_state_t;

    // what the head asks of the front end
    typedef enum logic [1:0] {
        rd_none       = 2'd0,
        rd_exception  = 2'd1,
        rd_mispredict = 2'd2
    } redirect_kind_t;

    // pc and kind are written at dispatch, the rest at completion
    typedef struct packed {
        logic [`XLEN-1:0]    pc;
        op_kind_t            kind;
        logic                mispred;   // branch resolved wrong
        logic [`CAUSE_W-1:0] cause;
        logic [`XLEN-1:0]    target;    // correct next pc of a branch
    } rob_payload_t;

endpackage

// ==== src/rob_params.svh ====
// ##################################################################
// sizes of the reorder buffer and commit stage
// ring depth, tag, address and cause widths, port counts
// ##################################################################

`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

`define ROB_DEPTH  16                        // ring entries
`define ROB_TAG_W  4                         // log2 of the depth
`define XLEN       32                        // pc and target width
`define CAUSE_W    5                         // exception cause code
`define COMMIT_W   2                         // retire slots per cycle
`define EXEC_W     2                         // completion ports

// retire count runs 0..COMMIT_W
`define RET_CNT_W  ($clog2(`COMMIT_W + 1))

`endif
